/* compile.f */
hdl/mult_pkg.sv
hdl/mult_stage.sv
hdl/mult_array.sv
hdl/tag_pipe.sv
hdl/complete_stage.sv
hdl/fu_mult.sv
sim/fu_mult_sva.sv
sim/fu_mult_tb.sv

/* hdl/complete_stage.sv */
`timescale 1ns/1ps

module complete_stage
	import mult_pkg::*;
(
	input  logic [2*XLEN-1:0]   product,
	input  logic                done,
	input  tag_t                tag,
	input  logic                complete_stall,
	output complete_packet_t    complete,
	output logic                want_to_complete,
	output logic                hold
);

	logic [XLEN-1:0] result;

	// MUL returns the low word, every MULH variant the high word
	always_comb begin
		if (tag.op == MUL) begin
			result = product[XLEN-1:0];
		end else begin
			result = product[2*XLEN-1:XLEN];
		end
	end

	always_comb begin
		complete            = '0;
		complete.valid      = done;
		complete.dest_pr    = tag.dest_pr;
		complete.rob_entry  = tag.rob_entry;
		complete.dest_value = result;
		complete.halt       = tag.halt;
	end

	assign want_to_complete = complete.valid;

	// a finished result that cannot leave freezes the whole unit
	assign hold = complete.valid & complete_stall;

endmodule

/* hdl/fu_mult.sv */
`timescale 1ns/1ps

module fu_mult
	import mult_pkg::*;
#(
	parameter int NUM_STAGE = 4
) (
	input  logic                clock,
	input  logic                reset,
	input  issue_packet_t       issue,
	input  logic                complete_stall,
	output logic                fu_ready,
	output logic                want_to_complete,
	output complete_packet_t    complete
);

	logic              accept;
	logic              advance;
	logic              hold;
	logic [1:0]        sign;
	tag_t              issue_tag;
	tag_t              final_tag;
	logic [2*XLEN-1:0] product;
	logic              product_done;

	assign advance  = ~hold;
	assign fu_ready = advance;
	assign accept   = issue.valid & fu_ready;

	// sign[0] is rs1 (multiplicand), sign[1] is rs2 (multiplier)
	always_comb begin
		case (issue.op)
			MUL, MULH: sign = 2'b11;
			MULHSU:    sign = 2'b01;
			default:   sign = 2'b00;
		endcase
	end

	always_comb begin
		issue_tag.op        = issue.op;
		issue_tag.dest_pr   = issue.dest_pr;
		issue_tag.rob_entry = issue.rob_entry;
		issue_tag.halt      = issue.halt;
	end

	mult_array #(
		.NUM_STAGE (NUM_STAGE)
	) mult_array_i (
		.clock   (clock),
		.reset   (reset),
		.advance (advance),
		.start   (accept),
		.sign    (sign),
		.mcand   (issue.r1_value),
		.mplier  (issue.r2_value),
		.product (product),
		.done    (product_done)
	);

	tag_pipe #(
		.NUM_STAGE (NUM_STAGE)
	) tag_pipe_i (
		.clock   (clock),
		.reset   (reset),
		.advance (advance),
		.start   (accept),
		.tag_in  (issue_tag),
		.tag_out (final_tag)
	);

	complete_stage complete_stage_i (
		.product          (product),
		.done             (product_done),
		.tag              (final_tag),
		.complete_stall   (complete_stall),
		.complete         (complete),
		.want_to_complete (want_to_complete),
		.hold             (hold)
	);

endmodule

/* hdl/mult_array.sv */
`timescale 1ns/1ps

module mult_array
	import mult_pkg::*;
#(
	parameter int NUM_STAGE = 4
) (
	input  logic                clock,
	input  logic                reset,
	input  logic                advance,
	input  logic                start,
	input  logic [1:0]          sign,
	input  logic [XLEN-1:0]     mcand,
	input  logic [XLEN-1:0]     mplier,
	output logic [2*XLEN-1:0]   product,
	output logic                done
);

	logic [2*XLEN-1:0] mcand_ext;
	logic [2*XLEN-1:0] mplier_ext;

	// index 0 is the chain input, index i+1 the output of stage i
	logic [NUM_STAGE:0][2*XLEN-1:0] stage_mcand;
	logic [NUM_STAGE:0][2*XLEN-1:0] stage_mplier;
	logic [NUM_STAGE:0][2*XLEN-1:0] stage_product;
	logic [NUM_STAGE:0]             stage_done;

	// sign[0] selects the multiplicand extension, sign[1] the multiplier
	assign mcand_ext  = sign[0] ? {{XLEN{mcand[XLEN-1]}}, mcand}
	                            : {{XLEN{1'b0}}, mcand};
	assign mplier_ext = sign[1] ? {{XLEN{mplier[XLEN-1]}}, mplier}
	                            : {{XLEN{1'b0}}, mplier};

	assign stage_mcand[0]   = mcand_ext;
	assign stage_mplier[0]  = mplier_ext;
	assign stage_product[0] = '0;
	assign stage_done[0]    = start;

	for (genvar i = 0; i < NUM_STAGE; i++) begin : g_stage
		mult_stage #(
			.NUM_STAGE (NUM_STAGE)
		) mult_stage_i (
			.clock       (clock),
			.reset       (reset),
			.advance     (advance),
			.start       (stage_done[i]),
			.product_in  (stage_product[i]),
			.mplier_in   (stage_mplier[i]),
			.mcand_in    (stage_mcand[i]),
			.done        (stage_done[i+1]),
			.product_out (stage_product[i+1]),
			.mplier_out  (stage_mplier[i+1]),
			.mcand_out   (stage_mcand[i+1])
		);
	end

	assign product = stage_product[NUM_STAGE];
	assign done    = stage_done[NUM_STAGE];

endmodule

/* hdl/mult_pkg.sv */
package mult_pkg;

	// operand width, fixed here since the packets depend on it
	localparam int XLEN = 32;

	// M-extension multiply operations
	typedef enum logic [1:0] {
		MUL    = 2'b00,
		MULH   = 2'b01,
		MULHSU = 2'b10,
		MULHU  = 2'b11
	} mult_op_t;

	// packet presented by the issue stage
	typedef struct packed {
		logic             valid;
		mult_op_t         op;
		logic [XLEN-1:0]  r1_value;
		logic [XLEN-1:0]  r2_value;
		logic [5:0]       dest_pr;
		logic [4:0]       rob_entry;
		logic             halt;
	} issue_packet_t;

	// metadata carried alongside the multiplier stages
	typedef struct packed {
		mult_op_t         op;
		logic [5:0]       dest_pr;
		logic [4:0]       rob_entry;
		logic             halt;
	} tag_t;

	// packet handed to the writeback side
	typedef struct packed {
		logic             valid;
		logic [5:0]       dest_pr;
		logic [4:0]       rob_entry;
		logic [XLEN-1:0]  dest_value;
		logic             halt;
	} complete_packet_t;

endpackage

/* hdl/mult_stage.sv */
`timescale 1ns/1ps

module mult_stage
	import mult_pkg::*;
#(
	parameter int NUM_STAGE = 4
) (
	input  logic                clock,
	input  logic                reset,
	input  logic                advance,
	input  logic                start,
	input  logic [2*XLEN-1:0]   product_in,
	input  logic [2*XLEN-1:0]   mplier_in,
	input  logic [2*XLEN-1:0]   mcand_in,
	output logic                done,
	output logic [2*XLEN-1:0]   product_out,
	output logic [2*XLEN-1:0]   mplier_out,
	output logic [2*XLEN-1:0]   mcand_out
);

	// multiplier bits consumed per stage
	localparam int NUM_BITS = (2 * XLEN) / NUM_STAGE;

	logic [2*XLEN-1:0] prod_in_reg;
	logic [2*XLEN-1:0] partial_prod;
	logic [2*XLEN-1:0] next_partial_prod;
	logic [2*XLEN-1:0] next_mplier;
	logic [2*XLEN-1:0] next_mcand;

	// low slice of the multiplier times the full multiplicand
	assign next_partial_prod = mplier_in[NUM_BITS-1:0] * mcand_in;

	assign next_mplier = mplier_in >> NUM_BITS;
	assign next_mcand  = mcand_in << NUM_BITS;

	// accumulate after the register to keep the adder off the input path
	assign product_out = prod_in_reg + partial_prod;

	always_ff @(posedge clock) begin
		if (advance) begin
			prod_in_reg  <= product_in;
			partial_prod <= next_partial_prod;
			mplier_out   <= next_mplier;
			mcand_out    <= next_mcand;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			done <= 1'b0;
		end else if (advance) begin
			done <= start;
		end
	end

endmodule

/* hdl/tag_pipe.sv */
`timescale 1ns/1ps

module tag_pipe
	import mult_pkg::*;
#(
	parameter int NUM_STAGE = 4
) (
	input  logic    clock,
	input  logic    reset,
	input  logic    advance,
	input  logic    start,
	input  tag_t    tag_in,
	output tag_t    tag_out
);

	// one slot per multiplier stage
	tag_t tag_q [NUM_STAGE];

	// first slot only picks up a tag when an operation enters
	always_ff @(posedge clock) begin
		if (reset) begin
			tag_q[0] <= '0;
		end else if (advance && start) begin
			tag_q[0] <= tag_in;
		end
	end

	// remaining slots shift with the multiplier
	for (genvar i = 1; i < NUM_STAGE; i++) begin : g_slot
		always_ff @(posedge clock) begin
			if (reset) begin
				tag_q[i] <= '0;
			end else if (advance) begin
				tag_q[i] <= tag_q[i-1];
			end
		end
	end

	// qualified downstream by the multiplier's done
	assign tag_out = tag_q[NUM_STAGE-1];

endmodule

/* run_sim.sh */
#!/bin/sh
# builds the fu_mult testbench with Verilator and runs it

build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert -j 0 \
	-f compile.f \
	--top-module fu_mult_tb \
	-o fu_mult_sim \
	> "$build_log" 2>&1 \
	|| { cat "$build_log"; echo "verilator build failed"; exit 1; }

./obj_dir/fu_mult_sim > "$sim_log" 2>&1 \
	|| { cat "$sim_log"; echo "simulation exited with an error"; exit 1; }

cat "$sim_log"
grep -q "SIMULATION FAILED" "$sim_log" && { echo "testbench reported failure"; exit 1; }
exit 0

/* sim/fu_mult_sva.sv */
`timescale 1ns/1ps

module fu_mult_sva
	import mult_pkg::*;
(
	input  logic                clock,
	input  logic                reset,
	input  logic                complete_stall,
	input  logic                fu_ready,
	input  logic                want_to_complete,
	input  complete_packet_t    complete
);

	// a held result stays put until it leaves
	complete_stable_a: assert property (@(posedge clock) disable iff (reset)
		(want_to_complete && complete_stall) |=> $stable(complete))
		else $error("complete packet changed while stalled");

	// ready drops only while a finished result is held
	fu_ready_a: assert property (@(posedge clock) disable iff (reset)
		fu_ready == !(want_to_complete && complete_stall))
		else $error("fu_ready does not match the held condition");

	reset_clears_a: assert property (@(posedge clock)
		reset |=> !want_to_complete)
		else $error("want_to_complete high in the cycle after reset");

endmodule

bind fu_mult fu_mult_sva fu_mult_sva_i (
	.clock            (clock),
	.reset            (reset),
	.complete_stall   (complete_stall),
	.fu_ready         (fu_ready),
	.want_to_complete (want_to_complete),
	.complete         (complete)
);

/* sim/fu_mult_tb.sv */
`timescale 1ns/1ps

module fu_mult_tb
	import mult_pkg::*;
();

	localparam int NUM_STAGE = 4;
	localparam int DRAIN_TIMEOUT = 100;
	localparam logic [31:0] CORNER [5] = '{32'hffffffff, 32'h80000000, 32'h0, 32'h1,
		32'h7fffffff};

	logic             clock;
	logic             reset;
	issue_packet_t    issue;
	logic             complete_stall;
	logic             fu_ready;
	logic             want_to_complete;
	complete_packet_t complete;

	// driver state
	logic [31:0] rng_state;
	logic [4:0]  next_rob;
	logic        check_latency;
	int          drive_errors = 0;
	int          test_count = 0;

	// monitor state
	complete_packet_t expected_q [$];
	int               accept_cycle_q [$];
	int               cycle_count = 0;
	int               accepted_count = 0;
	int               completed_count = 0;
	int               rejected_count = 0;
	int               error_count = 0;
	int               check_count = 0;

	fu_mult #(
		.NUM_STAGE (NUM_STAGE)
	) fu_mult_i (
		.clock            (clock),
		.reset            (reset),
		.issue            (issue),
		.complete_stall   (complete_stall),
		.fu_ready         (fu_ready),
		.want_to_complete (want_to_complete),
		.complete         (complete)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// full 64-bit product by the M-extension sign rules, then the half
	function automatic logic [31:0] expected_result(input mult_op_t op, input logic [31:0] a,
			input logic [31:0] b);
		longint      sa;
		longint      sb;
		longint      ua;
		longint      ub;
		logic [63:0] full;
		sa = longint'(signed'(a));
		sb = longint'(signed'(b));
		ua = longint'({32'd0, a});
		ub = longint'({32'd0, b});
		case (op)
			MUL, MULH: full = sa * sb;
			MULHSU:    full = sa * ub;
			default:   full = ua * ub;
		endcase
		if (op == MUL) begin
			return full[31:0];
		end
		return full[63:32];
	endfunction

	function automatic issue_packet_t make_packet(input mult_op_t op, input logic [31:0] a,
			input logic [31:0] b);
		issue_packet_t pkt;
		logic [31:0]   r;
		r = next_random();
		pkt.valid = 1'b1;
		pkt.op = op;
		pkt.r1_value = a;
		pkt.r2_value = b;
		pkt.dest_pr = r[5:0];
		pkt.rob_entry = next_rob;
		pkt.halt = r[6];
		next_rob = next_rob + 5'd1;
		return pkt;
	endfunction

	function automatic issue_packet_t random_packet();
		logic [31:0] r;
		r = next_random();
		return make_packet(mult_op_t'(r[1:0]), next_random(), next_random());
	endfunction

	function automatic int total_errors();
		return error_count + drive_errors;
	endfunction

	task automatic check_field(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		check_count++;
		assert (got === exp) else begin
			$display("mismatch %s: got %h, expected %h", name, got, exp);
			error_count++;
		end
	endtask

	task automatic present(input issue_packet_t pkt, input logic stall);
		@(posedge clock);
		issue <= pkt;
		complete_stall <= stall;
	endtask

	// stop issuing, release the stall and wait for the queue to empty
	task automatic wait_drain();
		int cycles;
		@(posedge clock);
		issue.valid <= 1'b0;
		complete_stall <= 1'b0;
		cycles = 0;
		@(negedge clock);
		while (expected_q.size() != 0 && cycles < DRAIN_TIMEOUT) begin
			@(negedge clock);
			cycles++;
		end
		if (expected_q.size() != 0) begin
			$display("timeout: %0d results still outstanding after %0d cycles",
				expected_q.size(), cycles);
			drive_errors++;
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		assert (accepted_count == completed_count) else begin
			$display("mismatch completed count: got %h, expected %h", completed_count,
				accepted_count);
			drive_errors++;
		end
		test_count++;
		if (total_errors() == errors_before) begin
			$display("test %0d %s: ok", test_count, name);
		end else begin
			$display("test %0d %s: failed with %0d errors", test_count, name,
				total_errors() - errors_before);
		end
	endtask

	// scoreboard, sampled on the rising edge before the DUT updates
	always @(posedge clock) begin : monitor
		complete_packet_t     exp_pkt;
		int                   accept_cycle;
		logic [NUM_STAGE-1:0] occupied;
		logic                 held;
		if (reset) begin
			occupied = '0;
		end else begin
			cycle_count++;
			// model of which stages hold an operation
			held = occupied[NUM_STAGE-1] && complete_stall;
			check_field("fu_ready", 32'(fu_ready), 32'(!held));
			check_field("want_to_complete", 32'(want_to_complete),
				32'(occupied[NUM_STAGE-1]));
			check_field("complete.valid", 32'(complete.valid), 32'(occupied[NUM_STAGE-1]));
			if (!held) begin
				occupied = {occupied[NUM_STAGE-2:0], issue.valid};
			end
			if (issue.valid && fu_ready) begin
				exp_pkt.valid = 1'b1;
				exp_pkt.dest_pr = issue.dest_pr;
				exp_pkt.rob_entry = issue.rob_entry;
				exp_pkt.dest_value = expected_result(issue.op, issue.r1_value, issue.r2_value);
				exp_pkt.halt = issue.halt;
				expected_q.push_back(exp_pkt);
				accept_cycle_q.push_back(cycle_count);
				accepted_count++;
			end else if (issue.valid) begin
				rejected_count++;
			end
			if (want_to_complete && !complete_stall) begin
				if (expected_q.size() == 0) begin
					$display("completion seen with no accepted issue outstanding");
					error_count++;
				end else begin
					exp_pkt = expected_q.pop_front();
					accept_cycle = accept_cycle_q.pop_front();
					completed_count++;
					check_field("complete.dest_pr", 32'(complete.dest_pr), 32'(exp_pkt.dest_pr));
					check_field("complete.rob_entry", 32'(complete.rob_entry),
						32'(exp_pkt.rob_entry));
					check_field("complete.dest_value", complete.dest_value, exp_pkt.dest_value);
					check_field("complete.halt", 32'(complete.halt), 32'(exp_pkt.halt));
					if (check_latency) begin
						check_field("latency", cycle_count - accept_cycle, NUM_STAGE);
					end
				end
			end
		end
	end

	initial begin
		int          errors_before;
		int          rejected_before;
		logic [31:0] r;
		issue_packet_t pkt;
		issue = '0;
		complete_stall = 1'b0;
		reset = 1'b1;
		rng_state = 32'h11da;
		next_rob = 5'd0;
		check_latency = 1'b1;
		repeat (2) @(posedge clock);
		reset <= 1'b0;

		errors_before = total_errors();
		@(negedge clock);
		assert (fu_ready === 1'b1) else begin
			$display("mismatch fu_ready after reset: got %h, expected 1", fu_ready);
			drive_errors++;
		end
		assert (want_to_complete === 1'b0) else begin
			$display("mismatch want_to_complete after reset: got %h, expected 0",
				want_to_complete);
			drive_errors++;
		end
		present(make_packet(MUL, next_random(), next_random()), 1'b0);
		wait_drain();
		report_test("single MUL after reset", errors_before);

		// every high-half operation on every corner pair
		errors_before = total_errors();
		for (int op_i = 1; op_i < 4; op_i++) begin
			for (int i = 0; i < 5; i++) begin
				for (int j = 0; j < 5; j++) begin
					present(make_packet(mult_op_t'(2'(op_i)), CORNER[i], CORNER[j]), 1'b0);
				end
			end
		end
		wait_drain();
		report_test("high halves on corner operands", errors_before);

		errors_before = total_errors();
		repeat (200) begin
			present(random_packet(), 1'b0);
		end
		wait_drain();
		report_test("back-to-back random issue", errors_before);

		// stalls stretch latency, so only order and contents are checked
		check_latency = 1'b0;
		errors_before = total_errors();
		repeat (300) begin
			r = next_random();
			present(random_packet(), r[1:0] == 2'd0);
		end
		wait_drain();
		report_test("random stall with continuous issue", errors_before);

		errors_before = total_errors();
		rejected_before = rejected_count;
		repeat (300) begin
			r = next_random();
			pkt = random_packet();
			pkt.valid = r[4];
			present(pkt, r[0]);
		end
		wait_drain();
		if (rejected_count == rejected_before) begin
			$display("no issue was ever presented while fu_ready was low");
			drive_errors++;
		end
		report_test("issue while not ready", errors_before);

		$display("tests %0d, checks %0d, accepted %0d, completed %0d, rejected %0d, errors %0d",
			test_count, check_count, accepted_count, completed_count, rejected_count,
			total_errors());
		if (total_errors() == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule
